// ==== design/sdram_pkg.sv ====
package sdram_pkg;

    // pin encoding {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        CMD_LOAD_MODE = 4'b0000,
        CMD_REFRESH   = 4'b0001,
        CMD_PRECHARGE = 4'b0010,
        CMD_ACTIVE    = 4'b0011,
        CMD_WRITE     = 4'b0100,
        CMD_READ      = 4'b0101,
        CMD_STOP      = 4'b0110,  // burst terminate
        CMD_NOP       = 4'b0111,
        CMD_INHIBIT   = 4'b1000
    } sdram_cmd_e;

    localparam int INIT_WAIT   = 20000; // 200 us at 100 MHz
    localparam int T_RP        = 2;
    localparam int T_RFC       = 11;
    localparam int T_RCD       = 2;
    localparam int T_WR_AP     = 4;     // engine recovery after rd/wr with auto-precharge
    localparam int CAS_LAT     = 2;
    localparam int REFRESH_INT = 780;   // 7.8 us
    localparam int NUM_BANKS   = 4;
    localparam int ROW_W       = 12;
    localparam int COL_W       = 8;
    localparam int BANK_W      = 2;

    typedef struct packed {
        logic [1:0] reserved;
        logic       wb_mode;    // 1 = single write
        logic [1:0] op_mode;
        logic [2:0] cas_lat;
        logic       burst_type; // 0 = sequential
        logic [2:0] burst_len;
    } mode_reg_t;

    typedef struct packed {
        logic       a11;
        logic       ap;         // a10, auto-precharge / all banks
        logic [9:0] a_lo;
    } addr_word_t;

    // same pins, load-mode view vs row/col view
    typedef union packed {
        mode_reg_t  mode;
        addr_word_t word;
    } sdram_addr_u;

    typedef struct packed {
        logic             wr;
        logic [ROW_W-1:0] row;
        logic [COL_W-1:0] col;
        logic [15:0]      wdata;
    } bank_req_t;

    typedef struct packed {
        sdram_cmd_e  cmd;
        sdram_addr_u addr;
        logic [15:0] wdata;
        logic        rd;
    } bank_cmd_t;

    typedef struct packed {
        logic [15:0] data;
    } rd_resp_t;

endpackage

// ==== design/sdram_init.sv ====
`timescale 1ns/1ps

module sdram_init import sdram_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    output logic        init_busy,
    output sdram_cmd_e  init_cmd,
    output sdram_addr_u init_addr
);

    logic [$clog2(INIT_WAIT+1)-1:0] wait_cnt;
    logic [2:0]                     step;      // 0 pre-all, 1..2 refresh, 3 load mode, 4 done

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            init_busy <= 1'b1;
            wait_cnt  <= INIT_WAIT[$bits(wait_cnt)-1:0]; // power-up wait
            step      <= '0;
            init_cmd  <= CMD_NOP;
            init_addr <= '0;
        end else if (init_busy) begin
            init_cmd <= CMD_NOP;  // one-cycle commands, nop otherwise
            if (wait_cnt != '0) begin
                wait_cnt <= wait_cnt - 1'b1;
            end else begin
                step <= step + 3'd1;
                case (step)
                    3'd0: begin
                        init_cmd       <= CMD_PRECHARGE;
                        init_addr.word <= '{a11: 1'b0, ap: 1'b1, a_lo: '0}; // all banks
                        wait_cnt       <= $bits(wait_cnt)'(T_RP);
                    end
                    3'd1, 3'd2: begin
                        init_cmd <= CMD_REFRESH;
                        wait_cnt <= $bits(wait_cnt)'(T_RFC);
                    end
                    3'd3: begin
                        init_cmd       <= CMD_LOAD_MODE;
                        // cl2, bl1, sequential
                        init_addr.mode <= '{reserved:   2'b00,
                                            wb_mode:    1'b1,
                                            op_mode:    2'b00,
                                            cas_lat:    3'(CAS_LAT),
                                            burst_type: 1'b0,
                                            burst_len:  3'b000};
                        wait_cnt       <= $bits(wait_cnt)'(3); // t_mrd plus margin
                    end
                    default: begin
                        init_busy <= 1'b0; // pins go to the arbiter
                    end
                endcase
            end
        end
    end

endmodule

// ==== design/axil_front.sv ====
`timescale 1ns/1ps

module axil_front import sdram_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    // aw / w / b
    input  logic [23:0]          awaddr,
    input  logic                 awvalid,
    output logic                 awready,
    input  logic [31:0]          wdata,
    input  logic [3:0]           wstrb,   // not decoded, full 16 bits written
    input  logic                 wvalid,
    output logic                 wready,
    output logic [1:0]           bresp,
    output logic                 bvalid,
    input  logic                 bready,
    // ar / r
    input  logic [23:0]          araddr,
    input  logic                 arvalid,
    output logic                 arready,
    output logic [31:0]          rdata,
    output logic [1:0]           rresp,
    output logic                 rvalid,
    input  logic                 rready,
    // controller side
    input  logic                 init_busy,
    input  logic                 refresh_pend,
    output bank_req_t            bank_req,
    output logic [NUM_BANKS-1:0] bank_req_valid,
    input  logic [NUM_BANKS-1:0] bank_ready,
    input  rd_resp_t             rd_resp,
    input  logic                 rd_resp_valid
);

    localparam int BA_LO = COL_W + ROW_W + 1; // word addr bit 0 is byte addr bit 1

    logic [BANK_W-1:0] aw_bank, ar_bank;
    logic              accept_ok;              // controller can take a new request
    logic              wr_ok, rd_ok;
    logic              rd_busy;                // one read in flight
    logic [15:0]       rdata_q;                // r skid register

    assign aw_bank   = awaddr[BA_LO+BANK_W-1:BA_LO];
    assign ar_bank   = araddr[BA_LO+BANK_W-1:BA_LO];
    assign accept_ok = !init_busy && !refresh_pend;

    // writes win over reads
    assign wr_ok = awvalid && wvalid && bank_ready[aw_bank] && accept_ok && !bvalid;
    assign rd_ok = arvalid && !wr_ok && bank_ready[ar_bank] && accept_ok && !rd_busy;

    assign awready = wr_ok;
    assign wready  = wr_ok;
    assign arready = rd_ok;
    assign bresp   = 2'b00; // always okay
    assign rresp   = 2'b00;
    assign rdata   = {16'h0000, rdata_q};

    always_comb begin
        bank_req_valid = '0;
        if (wr_ok) begin
            bank_req = '{wr: 1'b1, row: awaddr[BA_LO-1:COL_W+1], col: awaddr[COL_W:1],
                         wdata: wdata[15:0]};
            bank_req_valid[aw_bank] = 1'b1;
        end else begin
            bank_req = '{wr: 1'b0, row: araddr[BA_LO-1:COL_W+1], col: araddr[COL_W:1],
                         wdata: '0};
            bank_req_valid[ar_bank] = rd_ok;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
            rd_busy <= 1'b0;
        end else begin
            if (wr_ok) bvalid <= 1'b1;              // posted write
            else if (bready) bvalid <= 1'b0;
            if (rd_ok) rd_busy <= 1'b1;
            else if (rvalid && rready) rd_busy <= 1'b0;
            if (rd_resp_valid) rvalid <= 1'b1;
            else if (rready) rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_resp_valid) rdata_q <= rd_resp.data;
    end

endmodule

// ==== design/sdram_bank.sv ====
`timescale 1ns/1ps

module sdram_bank import sdram_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  bank_req_t req,
    input  logic      req_valid,
    output logic      req_ready,  // also the idle report for refresh
    output bank_cmd_t cmd_out,
    output logic      cmd_valid,
    input  logic      grant
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ACT,     // active waiting for grant
        ST_RCD,     // row to column delay
        ST_RW,      // read/write with auto-precharge
        ST_REC      // precharge recovery
    } state_e;

    state_e    state;
    logic [2:0] cnt;
    bank_req_t req_q;

    assign req_ready = (state == ST_IDLE);
    assign cmd_valid = (state == ST_ACT) || (state == ST_RW);

    always_comb begin
        cmd_out = '{cmd: CMD_NOP, addr: '0, wdata: req_q.wdata, rd: 1'b0};
        if (state == ST_ACT) begin
            cmd_out.cmd       = CMD_ACTIVE;
            cmd_out.addr.word = addr_word_t'(req_q.row);
        end else if (state == ST_RW) begin
            cmd_out.cmd       = req_q.wr ? CMD_WRITE : CMD_READ;
            cmd_out.addr.word = '{a11: 1'b0, ap: 1'b1, a_lo: {2'b00, req_q.col}};
            cmd_out.rd        = !req_q.wr;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                ST_IDLE: if (req_valid) state <= ST_ACT;
                ST_ACT: if (grant) begin
                    state <= ST_RCD;
                    cnt   <= 3'(T_RCD - 2); // pins lag grant by one
                end
                ST_RCD: if (cnt == '0) state <= ST_RW;
                        else cnt <= cnt - 3'd1;
                ST_RW: if (grant) begin
                    state <= ST_REC;
                    cnt   <= 3'(T_WR_AP - 1);
                end
                ST_REC: if (cnt == '0) state <= ST_IDLE;
                        else cnt <= cnt - 3'd1;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) req_q <= req;
    end

endmodule

// ==== design/sdram_cmd_arb.sv ====
`timescale 1ns/1ps

module sdram_cmd_arb import sdram_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 init_busy,
    input  sdram_cmd_e           init_cmd,
    input  sdram_addr_u          init_addr,
    input  bank_cmd_t            bank_cmd [NUM_BANKS],
    input  logic [NUM_BANKS-1:0] bank_valid,
    input  logic [NUM_BANKS-1:0] bank_idle,
    output logic [NUM_BANKS-1:0] grant,
    output logic                 refresh_pend,
    output rd_resp_t             rd_resp,
    output logic                 rd_resp_valid,
    // sdram pins
    output sdram_cmd_e           cmd,
    output sdram_addr_u          addr,
    output logic [BANK_W-1:0]    ba,
    output logic [15:0]          dq_out,
    output logic                 dq_oe,
    input  logic [15:0]          dq_in
);

    logic [BANK_W-1:0]                rr;        // round-robin start
    logic [BANK_W-1:0]                sel;
    logic                             any_valid, can_grant, fire_ref;
    logic [$clog2(REFRESH_INT)-1:0]   ref_cnt;
    logic [$clog2(T_RFC+1)-1:0]       hold_cnt;  // grants held after refresh
    logic [CAS_LAT+1:0]               rd_pipe;   // read cmd age in cycles
    logic [15:0]                      dq_q;      // input register

    always_comb begin
        logic [BANK_W-1:0] idx;
        sel       = rr;
        any_valid = 1'b0;
        for (int i = NUM_BANKS - 1; i >= 0; i--) begin  // nearest to rr wins
            idx = rr + BANK_W'(i);
            if (bank_valid[idx]) begin
                sel       = idx;
                any_valid = 1'b1;
            end
        end
    end

    assign can_grant = any_valid && !init_busy && (hold_cnt == '0);
    assign fire_ref  = refresh_pend && (&bank_idle) && (hold_cnt == '0) && !init_busy;

    always_comb begin
        grant = '0;
        if (can_grant) grant[sel] = 1'b1;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd           <= CMD_NOP;
            addr          <= '0;
            ba            <= '0;
            dq_oe         <= 1'b0;
            rr            <= '0;
            refresh_pend  <= 1'b0;
            ref_cnt       <= '0;
            hold_cnt      <= '0;
            rd_pipe       <= '0;
            rd_resp_valid <= 1'b0;
        end else begin
            cmd   <= CMD_NOP;
            dq_oe <= 1'b0;
            if (hold_cnt != '0) hold_cnt <= hold_cnt - 1'b1;
            if (init_busy) begin               // init owns the pins
                cmd     <= init_cmd;
                addr    <= init_addr;
                ref_cnt <= '0;
            end else if (fire_ref) begin
                cmd          <= CMD_REFRESH;
                refresh_pend <= 1'b0;
                hold_cnt     <= $bits(hold_cnt)'(T_RFC);
            end else begin
                if (can_grant) begin
                    cmd   <= bank_cmd[sel].cmd;
                    addr  <= bank_cmd[sel].addr;
                    ba    <= sel;
                    dq_oe <= (bank_cmd[sel].cmd == CMD_WRITE);
                    rr    <= sel + 1'b1;
                end
                if (!refresh_pend) begin
                    ref_cnt <= ref_cnt + 1'b1;
                    if (ref_cnt == $bits(ref_cnt)'(REFRESH_INT - 1)) begin
                        refresh_pend <= 1'b1;
                        ref_cnt      <= '0;
                    end
                end
            end
            rd_pipe       <= {rd_pipe[CAS_LAT:0], can_grant && bank_cmd[sel].rd};
            rd_resp_valid <= rd_pipe[CAS_LAT+1];   // dq_q holds cl-cycle data here
        end
    end

    always_ff @(posedge clk) begin
        if (can_grant) dq_out <= bank_cmd[sel].wdata;
        dq_q <= dq_in;
        if (rd_pipe[CAS_LAT+1]) rd_resp.data <= dq_q;
    end

endmodule

// ==== design/sdram_ctrl.sv ====
`timescale 1ns/1ps

module sdram_ctrl import sdram_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    // axi4-lite slave
    input  logic [23:0]       awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  logic [31:0]       wdata,
    input  logic [3:0]        wstrb,
    input  logic              wvalid,
    output logic              wready,
    output logic [1:0]        bresp,
    output logic              bvalid,
    input  logic              bready,
    input  logic [23:0]       araddr,
    input  logic              arvalid,
    output logic              arready,
    output logic [31:0]       rdata,
    output logic [1:0]        rresp,
    output logic              rvalid,
    input  logic              rready,
    // sdram
    output sdram_cmd_e        cmd,
    output sdram_addr_u       addr,
    output logic [BANK_W-1:0] ba,
    output logic [15:0]       dq_out,
    output logic              dq_oe,
    input  logic [15:0]       dq_in
);

    logic                 init_busy, refresh_pend, rd_resp_valid;
    sdram_cmd_e           init_cmd;
    sdram_addr_u          init_addr;
    bank_req_t            bank_req;
    logic [NUM_BANKS-1:0] bank_req_valid, bank_ready, bank_valid, grant;
    bank_cmd_t            bank_cmd [NUM_BANKS];
    rd_resp_t             rd_resp;

    sdram_init u_init (
        .clk, .rst, .init_busy, .init_cmd, .init_addr
    );

    axil_front u_front (
        .clk, .rst,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .init_busy, .refresh_pend, .bank_req, .bank_req_valid, .bank_ready,
        .rd_resp, .rd_resp_valid
    );

    // one engine per bank, same request bus
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        sdram_bank u_bank (
            .clk, .rst,
            .req       (bank_req),
            .req_valid (bank_req_valid[b]),
            .req_ready (bank_ready[b]),
            .cmd_out   (bank_cmd[b]),
            .cmd_valid (bank_valid[b]),
            .grant     (grant[b])
        );
    end

    sdram_cmd_arb u_arb (
        .clk, .rst, .init_busy, .init_cmd, .init_addr,
        .bank_cmd, .bank_valid,
        .bank_idle (bank_ready),   // idle engine = ready engine
        .grant, .refresh_pend, .rd_resp, .rd_resp_valid,
        .cmd, .addr, .ba, .dq_out, .dq_oe, .dq_in
    );

endmodule

// ==== dv/sdram_model.sv ====
`timescale 1ns/1ps

module sdram_model import sdram_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  sdram_cmd_e        cmd,
    input  sdram_addr_u       addr,
    input  logic [BANK_W-1:0] ba,
    input  logic [15:0]       dq_out,
    input  logic              dq_oe,
    output logic [15:0]       dq_in
);

    logic [15:0]      mem [logic [BANK_W+ROW_W+COL_W-1:0]];  // sparse storage
    logic [ROW_W-1:0] open_row [NUM_BANKS];
    int               act_cyc [NUM_BANKS];                  // cycle of last active per bank
    logic [15:0]      rd_stage;                             // first cas latency stage
    int               cyc, last_ref, init_step;
    logic             mode_set;
    int               errors = 0;

    task automatic flag_error(input string what);
        $display("protocol error at %0t ns: %s", $time, what);
        errors++;
    endtask

    always @(posedge clk or posedge rst) begin
        logic [BANK_W+ROW_W+COL_W-1:0] key;
        if (rst) begin
            cyc       = 0;
            last_ref  = -1000;
            init_step = 0;
            mode_set  = 1'b0;
            rd_stage <= '0;
            dq_in    <= '0;
        end else begin
            cyc++;
            key = {ba, open_row[ba], addr[COL_W-1:0]};
            dq_in    <= rd_stage;   // data valid cl cycles after the read
            rd_stage <= 16'hxxxx;   // mistimed capture shows up as x
            if (cmd != CMD_NOP && init_step < 4) begin
                case (init_step)
                    0: assert (cmd == CMD_PRECHARGE && addr.word.ap)
                        else flag_error("first init command is not precharge-all");
                    1, 2: assert (cmd == CMD_REFRESH)
                        else flag_error("init auto-refresh missing");
                    default: assert (cmd == CMD_LOAD_MODE && addr.mode.cas_lat == 3'(CAS_LAT)
                                     && addr.mode.burst_len == 3'b000)
                        else flag_error("load-mode missing or wrong cas latency/burst length");
                endcase
                init_step++;
            end
            if (!mode_set)
                assert (cmd != CMD_ACTIVE && cmd != CMD_READ && cmd != CMD_WRITE)
                    else flag_error("active, read or write before load-mode");
            if (cmd != CMD_NOP)
                assert (cyc - last_ref >= T_RFC) else flag_error("command inside refresh time");
            if (mode_set)
                assert (cyc - last_ref <= REFRESH_INT + 40) else begin
                    flag_error("refresh interval exceeded");
                    last_ref = cyc;  // one report per missed refresh
                end
            case (cmd)
                CMD_LOAD_MODE: mode_set = 1'b1;
                CMD_REFRESH:   last_ref = cyc;
                CMD_ACTIVE: begin
                    open_row[ba] = addr[ROW_W-1:0];
                    act_cyc[ba]  = cyc;
                end
                CMD_WRITE: begin
                    assert (cyc - act_cyc[ba] >= T_RCD) else flag_error("write before t_rcd");
                    assert (dq_oe) else flag_error("write without dq output enable");
                    mem[key] = dq_out;
                end
                CMD_READ: begin
                    assert (cyc - act_cyc[ba] >= T_RCD) else flag_error("read before t_rcd");
                    rd_stage <= mem.exists(key) ? mem[key] : 16'h0000;
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== dv/tb_sdram_ctrl.sv ====
`timescale 1ns/1ps

module tb_sdram_ctrl import sdram_pkg::*; ();

    localparam int N_TRANS     = 60;                        // bound over all tests
    localparam int TIMEOUT_CYC = INIT_WAIT + 300 * N_TRANS;

    logic              clk = 1'b0;
    logic              rst;
    logic [23:0]       awaddr, araddr;
    logic [31:0]       wdata, rdata;
    logic [3:0]        wstrb;
    logic              awvalid, awready, wvalid, wready, bvalid, bready;
    logic              arvalid, arready, rvalid, rready;
    logic [1:0]        bresp, rresp;
    sdram_cmd_e        cmd;
    sdram_addr_u       addr;
    logic [BANK_W-1:0] ba;
    logic [15:0]       dq_out, dq_in;
    logic              dq_oe;

    logic [31:0]       seed = 32'h43c3ecc5;
    logic [15:0]       ref_mem [logic [21:0]];  // expected contents by word address
    logic [23:0]       written [$];             // addresses safe to read back
    int                tb_errs = 0;

    always #5 clk = ~clk;

    sdram_ctrl u_dut (.*);
    sdram_model u_model (.*);

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [23:0] rand_addr();
        logic [31:0] r;
        r = next_rand();
        return {1'b0, r[22:1], 1'b0};  // bit 23 unused, halfword aligned
    endfunction

    task automatic check_data(input string name, input logic [15:0] exp, input logic [15:0] got);
        assert (got === exp) else begin
            $display("Fail %s: expected %h, actual %h", name, exp, got);
            tb_errs++;
        end
    endtask

    // aw and w together, returns on the falling edge after the handshake
    task automatic put_write(input logic [23:0] a, input logic [15:0] d);
        @(negedge clk);
        awaddr  = a;
        wdata   = {~d, d};     // upper half never reaches memory
        awvalid = 1'b1;
        wvalid  = 1'b1;
        #1;
        while (!(awready && wready)) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        ref_mem[a[22:1]] = d;
        written.push_back(a);
    endtask

    task automatic write_word(input logic [23:0] a, input logic [15:0] d);
        put_write(a, d);
        while (!bvalid) @(negedge clk);
        check_data("bresp", 16'h0000, 16'(bresp));  // okay
        @(negedge clk);        // b taken at the rising edge in between
    endtask

    task automatic put_read(input logic [23:0] a);
        @(negedge clk);
        araddr  = a;
        arvalid = 1'b1;
        #1;
        while (!arready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        arvalid = 1'b0;
    endtask

    task automatic read_check(input string name, input logic [23:0] a);
        put_read(a);
        while (!rvalid) @(negedge clk);
        check_data(name, ref_mem[a[22:1]], rdata[15:0]);
        check_data({name, " rresp"}, 16'h0000, 16'(rresp));
        @(negedge clk);
    endtask

    initial begin
        #(TIMEOUT_CYC * 10);
        $display("watchdog expired after %0d cycles, a handshake never completed", TIMEOUT_CYC);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [23:0] a;
        logic [23:0] sweep [NUM_BANKS];
        logic [15:0] held;

        rst     = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = 4'hf;
        wvalid  = 1'b0;
        bready  = 1'b1;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        assert (cmd == CMD_NOP && !dq_oe && !awready && !wready && !arready && !bvalid
                && !rvalid)
            else begin
                $display("pins or axi outputs not idle after reset");
                tb_errs++;
            end

        // first write waits out the power-up sequence
        a = rand_addr();
        r = next_rand();
        write_word(a, r[15:0]);
        read_check("single", a);

        // one write per bank back to back, read in reverse
        for (int b = 0; b < NUM_BANKS; b++) begin
            r = next_rand();
            sweep[b] = {1'b0, BANK_W'(b), r[20:1], 1'b0};
            write_word(sweep[b], r[31:16]);
        end
        for (int b = NUM_BANKS - 1; b >= 0; b--) read_check("bank_sweep", sweep[b]);

        // mixed traffic with idle gaps across several refresh periods
        for (int i = 0; i < 40; i++) begin
            r = next_rand();
            if (r[31] || written.size() == 0) begin
                a = rand_addr();
                write_word(a, r[15:0]);
            end else begin
                read_check("random", written[r[15:0] % written.size()]);
            end
            repeat (r[23:16] % 100) @(negedge clk);
        end

        // b held off, second write must wait
        a = rand_addr();
        r = next_rand();
        bready = 1'b0;
        put_write(a, r[15:0]);
        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            awaddr  = a ^ 24'h200000;  // other bank, its engine is idle
            awvalid = 1'b1;
            wvalid  = 1'b1;
            #1;
            assert (bvalid && !awready && !wready) else begin
                $display("bvalid dropped or a write was accepted while bready was low");
                tb_errs++;
            end
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;

        // r held off, data must stay put and no read accepted
        rready = 1'b0;
        put_read(a);
        while (!rvalid) @(negedge clk);
        held = rdata[15:0];
        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            araddr  = a ^ 24'h000002;
            arvalid = 1'b1;
            #1;
            assert (rvalid && rdata[15:0] === held && !arready) else begin
                $display("rvalid or rdata changed, or a read was accepted while rready was low");
                tb_errs++;
            end
        end
        @(negedge clk);
        arvalid = 1'b0;
        rready  = 1'b1;
        @(negedge clk);
        check_data("backpressure", ref_mem[a[22:1]], held);

        $display("errors: testbench %0d, protocol %0d", tb_errs, u_model.errors);
        if (tb_errs + u_model.errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
design/sdram_pkg.sv
design/sdram_init.sv
design/axil_front.sv
design/sdram_bank.sv
design/sdram_cmd_arb.sv
design/sdram_ctrl.sv
dv/sdram_model.sv
dv/tb_sdram_ctrl.sv
